// ==== tx_dma_pkg.sv ====
// widths, limits, completion header fields and parser states for the tx dma receive path
`default_nettype none

package tx_dma_pkg;

    ///////////////////////////////////////////////////////////////////////
    // data and pointer types
    ///////////////////////////////////////////////////////////////////////
    typedef logic [63:0] qword_t;
    typedef logic [9:0]  buf_ptr_t;       // one bit over the 9-bit buffer address
    typedef logic [1:0]  tag_t;
    typedef logic [9:0]  req_qwords_t;
    typedef logic [31:0] page_qwords_t;
    typedef logic [2:0]  req_count_t;     // wraps, only differences matter

    ///////////////////////////////////////////////////////////////////////
    // limits
    ///////////////////////////////////////////////////////////////////////
    localparam int MAX_READ_QWORDS = 16;  // 128 bytes per read
    localparam int MAX_OUTSTANDING = 4;
    localparam int BUF_QWORDS      = 512;
    localparam int NUM_TAGS        = 2 ** $bits(tag_t);

    ///////////////////////////////////////////////////////////////////////
    // completion header fields
    ///////////////////////////////////////////////////////////////////////
    localparam logic [6:0] CPLD_FMT_TYPE = 7'b10_01010;  // 3dw header with data
    localparam logic [2:0] CPL_STATUS_SC = 3'b000;

    typedef enum logic [1:0] {
        ST_HEADER,     // waiting for start of frame
        ST_TAG,        // second header beat, carries first data dword
        ST_PAYLOAD,
        ST_DROP        // foreign tlp, skip to end of frame
    } cpl_state_e;

endpackage

`default_nettype wire

// ==== cpl_beat_if.sv ====
// payload beat interface from the parser and read issue interface from the request generator
`timescale 1ns/1ps
`default_nettype none

interface cpl_beat_if import tx_dma_pkg::*; ();
    logic   beat_valid;  // one strobe per qword
    tag_t   beat_tag;
    qword_t beat_data;
    logic   beat_first;
    logic   beat_last;

    modport driver (output beat_valid, beat_tag, beat_data, beat_first, beat_last);
    modport sink   (input  beat_valid, beat_tag, beat_data, beat_first, beat_last);
endinterface

interface req_issue_if import tx_dma_pkg::*; ();
    logic        issue;         // request acknowledged by the core
    tag_t        issue_tag;
    buf_ptr_t    issue_addr;    // buffer region reserved for it
    req_qwords_t issue_qwords;

    modport driver (output issue, issue_tag, issue_addr, issue_qwords);
    modport sink   (input  issue, issue_tag, issue_addr, issue_qwords);
endinterface

`default_nettype wire

// ==== rd_request_gen.sv ====
// read request generator splitting one host page under outstanding and buffer space limits
`timescale 1ns/1ps
`default_nettype none

module rd_request_gen
    import tx_dma_pkg::*;
#(
    parameter int MAX_READ_QWORDS = tx_dma_pkg::MAX_READ_QWORDS,
    parameter int MAX_OUTSTANDING = tx_dma_pkg::MAX_OUTSTANDING
) (
    input  logic         trn_clk,
    input  logic         reset,
    input  logic         huge_page_status,
    input  logic [63:0]  huge_page_addr,
    input  page_qwords_t huge_page_qwords,
    output logic         huge_page_free,
    output logic         read_chunk,
    output logic [63:0]  huge_page_addr_read_from,
    output req_qwords_t  qwords_to_rd,
    input  tag_t         tlp_tag,
    input  logic         read_chunk_ack,
    output logic         send_rd_completed,
    input  logic         send_rd_completed_ack,
    input  buf_ptr_t     commited_rd_addr,
    input  req_count_t   completed_count,
    req_issue_if.driver  issue
);

    logic         page_active;
    logic         page_start;
    logic         start_read;
    logic [63:0]  rd_addr;         // host address of next request
    page_qwords_t remaining;
    buf_ptr_t     next_wr_ptr;
    req_count_t   issued_count;
    req_count_t   outstanding;
    buf_ptr_t     free_space;
    req_qwords_t  chunk_qwords;

    assign chunk_qwords = (remaining < page_qwords_t'(MAX_READ_QWORDS)) ?
                          req_qwords_t'(remaining) : req_qwords_t'(MAX_READ_QWORDS);
    assign outstanding  = issued_count - completed_count;
    assign free_space   = buf_ptr_t'(BUF_QWORDS) - (next_wr_ptr - commited_rd_addr);
    assign page_start   = !page_active && huge_page_status && !send_rd_completed;
    assign start_read   = page_active && !read_chunk && (remaining != '0)
                          && (outstanding < MAX_OUTSTANDING) && (free_space >= chunk_qwords);

    ///////////////////////////////////////////////////////////////////////
    // request sequencing
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            page_active       <= 1'b0;
            read_chunk        <= 1'b0;
            send_rd_completed <= 1'b0;
            huge_page_free    <= 1'b0;
            issue.issue       <= 1'b0;
            next_wr_ptr       <= '0;
            issued_count      <= '0;
        end else begin
            huge_page_free <= 1'b0;
            issue.issue    <= 1'b0;
            if (send_rd_completed_ack) begin
                send_rd_completed <= 1'b0;
            end
            if (page_start) begin
                page_active <= 1'b1;
            end else if (read_chunk && read_chunk_ack) begin
                read_chunk   <= 1'b0;
                issue.issue  <= 1'b1;                     // one cycle after the ack
                next_wr_ptr  <= next_wr_ptr + qwords_to_rd;
                issued_count <= issued_count + 1'b1;
            end else if (page_active && !read_chunk && remaining == '0) begin
                page_active       <= 1'b0;                // whole page requested
                huge_page_free    <= 1'b1;
                send_rd_completed <= 1'b1;
            end else if (start_read) begin
                read_chunk <= 1'b1;
            end
        end
    end

    always_ff @(posedge trn_clk) begin
        if (page_start) begin
            rd_addr   <= huge_page_addr;
            remaining <= huge_page_qwords;
        end
        if (start_read) begin
            huge_page_addr_read_from <= rd_addr;
            qwords_to_rd             <= chunk_qwords;
        end
        if (read_chunk && read_chunk_ack) begin
            rd_addr            <= rd_addr + {qwords_to_rd, 3'b000};  // qwords to bytes
            remaining          <= remaining - qwords_to_rd;
            issue.issue_tag    <= tlp_tag;                           // tag valid with the ack
            issue.issue_addr   <= next_wr_ptr;
            issue.issue_qwords <= qwords_to_rd;
        end
    end

endmodule

`default_nettype wire

// ==== cpl_parser.sv ====
// completion parser with header checks, dword realignment and per-dword byte swap
`timescale 1ns/1ps
`default_nettype none

module cpl_parser
    import tx_dma_pkg::*;
(
    input  logic       trn_clk,
    input  logic       reset,
    input  qword_t     trn_rd,
    input  logic       trn_rsof_n,
    input  logic       trn_reof_n,
    input  logic       trn_rsrc_rdy_n,
    input  logic       trn_rdst_rdy_n,
    cpl_beat_if.driver beats
);

    cpl_state_e  state;
    logic        rx_beat;
    logic        hdr_ok;
    logic        first_pending;
    logic [31:0] dw_hold;        // low dword of previous beat

    function automatic logic [31:0] swap_dw(input logic [31:0] dw);
        return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
    endfunction

    assign rx_beat = !trn_rsrc_rdy_n && !trn_rdst_rdy_n;
    assign hdr_ok  = (trn_rd[62:56] == CPLD_FMT_TYPE) && (trn_rd[15:13] == CPL_STATUS_SC)
                     && !trn_rd[32];                 // even dword count only

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state            <= ST_HEADER;
            beats.beat_valid <= 1'b0;
        end else begin
            beats.beat_valid <= 1'b0;
            if (rx_beat) begin
                case (state)
                    ST_HEADER: begin
                        if (!trn_rsof_n && trn_reof_n) begin
                            state <= hdr_ok ? ST_TAG : ST_DROP;
                        end
                    end
                    ST_TAG: begin
                        beats.beat_tag <= trn_rd[41:40];
                        dw_hold        <= trn_rd[31:0];  // first data dword
                        first_pending  <= 1'b1;
                        if (!trn_reof_n) begin
                            state <= ST_HEADER;
                        end else begin
                            state <= (trn_rd[47:42] == '0) ? ST_PAYLOAD : ST_DROP;
                        end
                    end
                    ST_PAYLOAD: begin
                        beats.beat_valid <= 1'b1;
                        beats.beat_data  <= {swap_dw(trn_rd[63:32]), swap_dw(dw_hold)};
                        beats.beat_first <= first_pending;
                        beats.beat_last  <= !trn_reof_n;
                        first_pending    <= 1'b0;
                        dw_hold          <= trn_rd[31:0];
                        if (!trn_reof_n) begin
                            state <= ST_HEADER;
                        end
                    end
                    default: begin                       // ST_DROP
                        if (!trn_reof_n) begin
                            state <= ST_HEADER;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== bram_writer.sv ====
// buffer writer with per-tag write pointers and completion size counting
`timescale 1ns/1ps
`default_nettype none

module bram_writer
    import tx_dma_pkg::*;
(
    input  logic        trn_clk,
    input  logic        reset,
    cpl_beat_if.sink    beats,
    req_issue_if.sink   issue,
    output logic [8:0]  wr_addr,
    output qword_t      wr_data,
    output logic        wr_en,
    output logic        cpl_done,
    output tag_t        cpl_done_tag,
    output req_qwords_t cpl_done_qwords
);

    buf_ptr_t    wr_ptr [NUM_TAGS];   // next qword slot per tag
    req_qwords_t cpl_qwords;         // qwords of current completion
    tag_t        last_tag;
    logic        last_written;

    ///////////////////////////////////////////////////////////////////////
    // pointer table
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (beats.beat_valid) begin
            wr_ptr[beats.beat_tag] <= wr_ptr[beats.beat_tag] + 1'b1;
        end
        if (issue.issue) begin
            wr_ptr[issue.issue_tag] <= issue.issue_addr;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // write port and done strobe
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            wr_en        <= 1'b0;
            last_written <= 1'b0;
            cpl_done     <= 1'b0;
        end else begin
            wr_en        <= beats.beat_valid;
            last_written <= beats.beat_valid && beats.beat_last;
            cpl_done     <= last_written;          // one cycle after last write
        end
    end

    always_ff @(posedge trn_clk) begin
        wr_addr         <= wr_ptr[beats.beat_tag][8:0];
        wr_data         <= beats.beat_data;
        cpl_done_tag    <= last_tag;
        cpl_done_qwords <= cpl_qwords;
        if (beats.beat_valid) begin
            cpl_qwords <= beats.beat_first ? req_qwords_t'(1) : cpl_qwords + 1'b1;
            last_tag   <= beats.beat_tag;
        end
    end

endmodule

`default_nettype wire

// ==== commit_tracker.sv ====
// per-tag request bookkeeping and in-order advance of the committed write address
`timescale 1ns/1ps
`default_nettype none

module commit_tracker
    import tx_dma_pkg::*;
#(
    parameter int MAX_OUTSTANDING = tx_dma_pkg::MAX_OUTSTANDING
) (
    input  logic        trn_clk,
    input  logic        reset,
    req_issue_if.sink   issue,
    input  logic        cpl_done,
    input  tag_t        cpl_done_tag,
    input  req_qwords_t cpl_done_qwords,
    output buf_ptr_t    commited_wr_addr,
    output req_count_t  completed_count
);

    buf_ptr_t      req_base [NUM_TAGS];
    req_qwords_t   req_size [NUM_TAGS];
    req_qwords_t   req_rcvd [NUM_TAGS];
    logic [NUM_TAGS-1:0] pending;
    tag_t          oldest;               // tags are handed out in order
    req_qwords_t   oldest_rcvd;
    logic          oldest_done;

    // include a completion landing this cycle
    assign oldest_rcvd = req_rcvd[oldest] +
                         ((cpl_done && cpl_done_tag == oldest) ? cpl_done_qwords : '0);
    assign oldest_done = pending[oldest] && (oldest_rcvd == req_size[oldest]);

    always_ff @(posedge trn_clk) begin
        if (cpl_done) begin
            req_rcvd[cpl_done_tag] <= req_rcvd[cpl_done_tag] + cpl_done_qwords;
        end
        if (issue.issue) begin
            req_base[issue.issue_tag] <= issue.issue_addr;
            req_size[issue.issue_tag] <= issue.issue_qwords;
            req_rcvd[issue.issue_tag] <= '0;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // in-order commit, one request per cycle
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            pending          <= '0;
            oldest           <= '0;
            completed_count  <= '0;
            commited_wr_addr <= '0;
        end else begin
            if (oldest_done) begin
                commited_wr_addr <= req_base[oldest] + req_size[oldest];
                pending[oldest]  <= 1'b0;
                oldest           <= (oldest == tag_t'(MAX_OUTSTANDING - 1)) ? '0 : oldest + 1'b1;
                completed_count  <= completed_count + 1'b1;
            end
            if (issue.issue) begin
                pending[issue.issue_tag] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tx_wr_pkt_to_bram.sv ====
// top level of the tx dma receive path, completions into the transmit buffer
`timescale 1ns/1ps
`default_nettype none

module tx_wr_pkt_to_bram
    import tx_dma_pkg::*;
#(
    parameter int MAX_READ_QWORDS = tx_dma_pkg::MAX_READ_QWORDS,
    parameter int MAX_OUTSTANDING = tx_dma_pkg::MAX_OUTSTANDING
) (
    input  logic         trn_clk,
    input  logic         reset,
    input  qword_t       trn_rd,
    input  logic         trn_rsof_n,
    input  logic         trn_reof_n,
    input  logic         trn_rsrc_rdy_n,
    input  logic         trn_rdst_rdy_n,
    input  logic         huge_page_status,
    input  logic [63:0]  huge_page_addr,
    input  page_qwords_t huge_page_qwords,
    output logic         huge_page_free,
    output logic         read_chunk,
    output logic [63:0]  huge_page_addr_read_from,
    output req_qwords_t  qwords_to_rd,
    input  tag_t         tlp_tag,
    input  logic         read_chunk_ack,
    output logic         send_rd_completed,
    input  logic         send_rd_completed_ack,
    output logic [8:0]   wr_addr,
    output qword_t       wr_data,
    output logic         wr_en,
    input  buf_ptr_t     commited_rd_addr,
    output buf_ptr_t     commited_wr_addr
);

    cpl_beat_if  beats ();
    req_issue_if issue ();

    logic        cpl_done;
    tag_t        cpl_done_tag;
    req_qwords_t cpl_done_qwords;
    req_count_t  completed_count;

    rd_request_gen #(
        .MAX_READ_QWORDS (MAX_READ_QWORDS),
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_rd_request_gen (
        .trn_clk, .reset,
        .huge_page_status, .huge_page_addr, .huge_page_qwords, .huge_page_free,
        .read_chunk, .huge_page_addr_read_from, .qwords_to_rd, .tlp_tag, .read_chunk_ack,
        .send_rd_completed, .send_rd_completed_ack,
        .commited_rd_addr, .completed_count,
        .issue           (issue.driver)
    );

    cpl_parser u_cpl_parser (
        .trn_clk, .reset,
        .trn_rd, .trn_rsof_n, .trn_reof_n, .trn_rsrc_rdy_n, .trn_rdst_rdy_n,
        .beats           (beats.driver)
    );

    bram_writer u_bram_writer (
        .trn_clk, .reset,
        .beats           (beats.sink),
        .issue           (issue.sink),
        .wr_addr, .wr_data, .wr_en,
        .cpl_done, .cpl_done_tag, .cpl_done_qwords
    );

    commit_tracker #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_commit_tracker (
        .trn_clk, .reset,
        .issue           (issue.sink),
        .cpl_done, .cpl_done_tag, .cpl_done_qwords,
        .commited_wr_addr, .completed_count
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// testbench clock and synchronous reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int CLK_PERIOD   = 100,  // ns
    parameter int RESET_CYCLES = 16
) (
    output logic trn_clk,
    output logic reset
);

    initial begin
        trn_clk = 1'b0;
        forever #(CLK_PERIOD / 2) trn_clk = ~trn_clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge trn_clk);
        #1 reset = 1'b0;                   // released just after an edge
    end

endmodule

`default_nettype wire

// ==== tb_tx_wr_pkt_to_bram.sv ====
// directed tests with host and buffer models, compare tasks and watchdog for the tx dma receive path
`timescale 1ns/1ps
`default_nettype none

module tb_tx_wr_pkt_to_bram
    import tx_dma_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 1;        // ns after the rising edge
    localparam int RANDOM_SEED  = 40068;
    localparam int WAIT_LIMIT   = 200;      // cycles for any single handshake
    // completion beats over all tests, header beats included
    localparam int TEST_BEATS      = 12 + 46 + 90 + 72 + 29;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 * TEST_BEATS;

    logic         trn_clk;
    logic         reset;
    qword_t       trn_rd;
    logic         trn_rsof_n;
    logic         trn_reof_n;
    logic         trn_rsrc_rdy_n;
    logic         trn_rdst_rdy_n;
    logic         huge_page_status;
    logic [63:0]  huge_page_addr;
    page_qwords_t huge_page_qwords;
    logic         huge_page_free;
    logic         read_chunk;
    logic [63:0]  huge_page_addr_read_from;
    req_qwords_t  qwords_to_rd;
    tag_t         tlp_tag;
    logic         read_chunk_ack;
    logic         send_rd_completed;
    logic         send_rd_completed_ack;
    logic [8:0]   wr_addr;
    qword_t       wr_data;
    logic         wr_en;
    buf_ptr_t     commited_rd_addr;
    buf_ptr_t     commited_wr_addr;

    qword_t       buf_mem [BUF_QWORDS];     // what the dut wrote
    qword_t       exp_mem [BUF_QWORDS];     // what it should have written
    int           write_count;
    qword_t       tlp_q [$];
    logic [31:0]  cpl_dw [33];              // payload dwords plus one pad
    tag_t         next_tag;
    buf_ptr_t     exp_next_ptr;
    buf_ptr_t     exp_commit;
    buf_ptr_t     req_base [NUM_TAGS];
    req_qwords_t  req_len [NUM_TAGS];

    tb_clock_gen #(.CLK_PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .trn_clk (trn_clk),
        .reset   (reset)
    );

    tx_wr_pkt_to_bram dut (.*);

    // buffer model
    always @(negedge trn_clk) begin
        if (wr_en === 1'b1) begin
            buf_mem[wr_addr] = wr_data;
            write_count++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // error handling and compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_qword(input string name, input qword_t actual, input qword_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_ptr(input string name, input buf_ptr_t actual, input buf_ptr_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_len(input string name, input req_qwords_t actual,
                             input req_qwords_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
            stop_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // host model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] byte_reverse(input logic [31:0] dw);
        return {<<8{dw}};
    endfunction

    task automatic next_drive_slot();
        @(posedge trn_clk);
        #DRIVE_DELAY;
    endtask

    task automatic set_rd_addr(input buf_ptr_t ptr);
        next_drive_slot();
        commited_rd_addr = ptr;                // consumer position
    endtask

    task automatic offer_page(input logic [63:0] addr, input page_qwords_t qwords);
        next_drive_slot();
        huge_page_status = 1'b1;
        huge_page_addr   = addr;
        huge_page_qwords = qwords;
    endtask

    task automatic wait_read(input logic [63:0] exp_addr, input req_qwords_t exp_qwords,
                             output tag_t tag);
        int waited;
        int delay;
        waited = 0;
        @(negedge trn_clk);
        while (read_chunk !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge trn_clk);
            waited++;
        end
        if (read_chunk !== 1'b1) report_error("no read request appeared");
        check_qword("huge_page_addr_read_from", huge_page_addr_read_from, exp_addr);
        check_len("qwords_to_rd", qwords_to_rd, exp_qwords);
        delay = $urandom % 4;
        repeat (delay) @(posedge trn_clk);     // late acknowledge
        next_drive_slot();
        read_chunk_ack = 1'b1;
        tlp_tag        = next_tag;
        next_drive_slot();
        read_chunk_ack = 1'b0;
        tag               = next_tag;
        req_base[tag]     = exp_next_ptr;
        req_len[tag]      = exp_qwords;
        exp_next_ptr      = exp_next_ptr + exp_qwords;
        next_tag          = next_tag + 1'b1;   // tags handed out in order
    endtask

    task automatic expect_no_read(input int cycles);
        repeat (cycles) begin
            @(negedge trn_clk);
            check_bit("read_chunk", read_chunk, 1'b0);
        end
    endtask

    task automatic finish_page();
        int waited;
        waited = 0;
        @(negedge trn_clk);
        while (huge_page_free !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge trn_clk);
            waited++;
        end
        if (huge_page_free !== 1'b1) report_error("huge_page_free never pulsed");
        check_bit("send_rd_completed", send_rd_completed, 1'b1);
        next_drive_slot();
        huge_page_status = 1'b0;               // host takes the page back
        @(negedge trn_clk);
        check_bit("huge_page_free", huge_page_free, 1'b0);
        repeat (3) begin
            @(negedge trn_clk);
            check_bit("send_rd_completed", send_rd_completed, 1'b1);
        end
        next_drive_slot();
        send_rd_completed_ack = 1'b1;
        next_drive_slot();
        send_rd_completed_ack = 1'b0;
        @(negedge trn_clk);
        check_bit("send_rd_completed", send_rd_completed, 1'b0);
    endtask

    // 3dw completion header, then dword 0 beside the tag, then dword pairs
    task automatic build_tlp(input tag_t tag, input logic [6:0] fmt_type,
                             input logic [2:0] status, input int dwords);
        logic [9:0]  len;
        logic [11:0] byte_count;
        len        = 10'(dwords);
        byte_count = 12'(dwords * 4);
        tlp_q.delete();
        for (int i = 0; i <= dwords; i++) begin
            cpl_dw[i] = $urandom;
        end
        tlp_q.push_back({1'b0, fmt_type, 8'h00, 6'h00, len,
                         16'h0100, status, 1'b0, byte_count});
        tlp_q.push_back({16'h0000, 6'h00, tag, 8'h00, cpl_dw[0]});
        for (int k = 1; k <= dwords / 2; k++) begin
            tlp_q.push_back({cpl_dw[2 * k - 1], cpl_dw[2 * k]});
        end
    endtask

    task automatic drive_tlp(input bit stall);
        for (int i = 0; i < tlp_q.size(); i++) begin
            if (stall && i > 0 && ($urandom % 2) == 1) begin
                next_drive_slot();
                trn_rsrc_rdy_n = 1'b1;         // source stall, junk on the bus
                trn_rsof_n     = 1'b1;
                trn_reof_n     = 1'b1;
                trn_rd         = {$urandom, $urandom};
            end
            next_drive_slot();
            trn_rd         = tlp_q[i];
            trn_rsof_n     = (i != 0);
            trn_reof_n     = (i != tlp_q.size() - 1);
            trn_rsrc_rdy_n = 1'b0;
        end
        next_drive_slot();
        trn_rsrc_rdy_n = 1'b1;
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b1;
    endtask

    task automatic send_completion(input tag_t tag, input bit stall);
        int       n;
        buf_ptr_t ptr;
        n = int'(req_len[tag]);
        build_tlp(tag, CPLD_FMT_TYPE, CPL_STATUS_SC, 2 * n);
        for (int k = 0; k < n; k++) begin
            ptr = req_base[tag] + buf_ptr_t'(k);
            exp_mem[ptr[8:0]] = {byte_reverse(cpl_dw[2 * k + 1]), byte_reverse(cpl_dw[2 * k])};
        end
        drive_tlp(stall);
    endtask

    task automatic wait_commit(input buf_ptr_t expected);
        int waited;
        waited = 0;
        @(negedge trn_clk);
        while (commited_wr_addr !== expected && waited < WAIT_LIMIT) begin
            @(negedge trn_clk);
            waited++;
        end
        check_ptr("commited_wr_addr", commited_wr_addr, expected);
    endtask

    task automatic check_request_data(input tag_t tag);
        buf_ptr_t ptr;
        for (int k = 0; k < int'(req_len[tag]); k++) begin
            ptr = req_base[tag] + buf_ptr_t'(k);
            check_qword($sformatf("buffer[%0d]", ptr[8:0]), buf_mem[ptr[8:0]], exp_mem[ptr[8:0]]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic idle_after_reset();
        repeat (10) begin
            @(negedge trn_clk);
            check_bit("read_chunk", read_chunk, 1'b0);
            check_bit("send_rd_completed", send_rd_completed, 1'b0);
            check_bit("huge_page_free", huge_page_free, 1'b0);
            check_bit("wr_en", wr_en, 1'b0);
            check_ptr("commited_wr_addr", commited_wr_addr, '0);
        end
    endtask

    task automatic single_chunk_page();
        tag_t t;
        set_rd_addr(exp_commit);
        offer_page(64'h0000_0001_0000_0000, 10);
        wait_read(64'h0000_0001_0000_0000, 10, t);
        finish_page();
        send_completion(t, 1'b0);
        exp_commit = exp_commit + 10;
        wait_commit(exp_commit);
        check_request_data(t);
    endtask

    task automatic split_page();
        tag_t t [3];
        set_rd_addr(exp_commit);
        offer_page(64'h0000_0002_0000_1000, 40);
        wait_read(64'h0000_0002_0000_1000, 16, t[0]);
        wait_read(64'h0000_0002_0000_1080, 16, t[1]);
        wait_read(64'h0000_0002_0000_1100, 8, t[2]);
        finish_page();
        for (int i = 0; i < 3; i++) begin
            send_completion(t[i], 1'b0);
        end
        exp_commit = exp_commit + 40;
        wait_commit(exp_commit);
        for (int i = 0; i < 3; i++) begin
            check_request_data(t[i]);
        end
    endtask

    task automatic reverse_order_completions();
        tag_t t [5];
        set_rd_addr(exp_commit);
        offer_page(64'h0000_0003_0000_0000, 80);
        for (int i = 0; i < 4; i++) begin
            wait_read(64'h0000_0003_0000_0000 + 64'(128 * i), 16, t[i]);
        end
        expect_no_read(20);                    // four in flight
        for (int i = 3; i > 0; i--) begin
            send_completion(t[i], 1'b0);
        end
        repeat (5) @(negedge trn_clk);
        check_ptr("commited_wr_addr", commited_wr_addr, exp_commit);
        send_completion(t[0], 1'b0);
        exp_commit = exp_commit + 64;
        wait_commit(exp_commit);
        for (int i = 0; i < 4; i++) begin
            check_request_data(t[i]);
        end
        wait_read(64'h0000_0003_0000_0200, 16, t[4]);
        finish_page();
        send_completion(t[4], 1'b0);
        exp_commit = exp_commit + 16;
        wait_commit(exp_commit);
        check_request_data(t[4]);
    endtask

    task automatic buffer_space_stall();
        tag_t t [4];
        set_rd_addr(exp_next_ptr - buf_ptr_t'(464));   // room for 48 qwords
        offer_page(64'h0000_0004_0000_0000, 64);
        for (int i = 0; i < 3; i++) begin
            wait_read(64'h0000_0004_0000_0000 + 64'(128 * i), 16, t[i]);
            send_completion(t[i], 1'b0);
        end
        expect_no_read(20);                    // buffer full
        set_rd_addr(commited_rd_addr + buf_ptr_t'(16));
        wait_read(64'h0000_0004_0000_0180, 16, t[3]);
        finish_page();
        send_completion(t[3], 1'b0);
        exp_commit = exp_commit + 64;
        wait_commit(exp_commit);
        for (int i = 0; i < 4; i++) begin
            check_request_data(t[i]);
        end
    endtask

    task automatic foreign_and_stalled_tlps();
        tag_t t;
        int   writes_before;
        set_rd_addr(exp_commit);
        writes_before = write_count;
        build_tlp(2'd0, 7'b10_00000, CPL_STATUS_SC, 4);   // memory write, not a completion
        drive_tlp(1'b0);
        build_tlp(2'd0, CPLD_FMT_TYPE, 3'b001, 4);         // unsupported request status
        drive_tlp(1'b0);
        build_tlp(2'd0, CPLD_FMT_TYPE, CPL_STATUS_SC, 3);  // odd dword count
        drive_tlp(1'b0);
        repeat (4) @(negedge trn_clk);
        if (write_count != writes_before) report_error("a foreign TLP wrote into the buffer");
        offer_page(64'h0000_0005_0000_0000, 16);
        wait_read(64'h0000_0005_0000_0000, 16, t);
        finish_page();
        send_completion(t, 1'b1);
        exp_commit = exp_commit + 16;
        wait_commit(exp_commit);
        check_request_data(t);
    endtask

    //////////////////////////////////////////////////////////////////////
    // watchdog and main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_error("watchdog expired, the run hung");
    end

    initial begin
        void'($urandom(RANDOM_SEED));
        trn_rd                = '0;
        trn_rsof_n            = 1'b1;
        trn_reof_n            = 1'b1;
        trn_rsrc_rdy_n        = 1'b1;
        trn_rdst_rdy_n        = 1'b0;       // always ready to take beats
        huge_page_status      = 1'b0;
        huge_page_addr        = '0;
        huge_page_qwords      = '0;
        tlp_tag               = '0;
        read_chunk_ack        = 1'b0;
        send_rd_completed_ack = 1'b0;
        commited_rd_addr      = '0;
        write_count           = 0;
        next_tag              = '0;
        exp_next_ptr          = '0;
        exp_commit            = '0;
        wait (reset === 1'b0);
        idle_after_reset();
        single_chunk_page();
        split_page();
        reverse_order_completions();
        buffer_space_stall();
        foreign_and_stalled_tlps();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
tx_dma_pkg.sv
cpl_beat_if.sv
rd_request_gen.sv
cpl_parser.sv
bram_writer.sv
commit_tracker.sv
tx_wr_pkt_to_bram.sv
tb_clock_gen.sv
tb_tx_wr_pkt_to_bram.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_tx_wr_pkt_to_bram -f list.f \
    -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1
grep -q '\*\*\* PASSED \*\*\*' sim.log || exit 1
exit 0
